//--- Makefile
# Verilator build and run for the LC4 pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_lc4_processor
FILELIST  ?= lc4_processor.f
GOLDEN    ?= lc4_golden.txt
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(GOLDEN)
	./$(SIM) | tee $(LOG)
	@grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- lc4_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_alu
    import lc4_isa_pkg::*;
(
    input  wire word_t i_insn,
    input  wire word_t i_pc,
    input  wire word_t i_rs_data,
    input  wire word_t i_rt_data,
    output word_t      o_result
);

    insn_u insn;
    word_t imm5_sx;
    word_t imm6_sx;
    word_t imm9_sx;

    assign insn    = i_insn;
    assign imm5_sx = {{11{i_insn[4]}}, i_insn[4:0]};  // spans subop[1:0] and rt
    assign imm6_sx = {{10{insn.mem.imm6[5]}}, insn.mem.imm6};
    assign imm9_sx = {{7{insn.imm9.imm9[8]}}, insn.imm9.imm9};

    always_comb begin
        case (insn.rrr.opcode)
            OP_ARITH: begin
                if (i_insn[SUBOP_IMM_BIT])
                    o_result = i_rs_data + imm5_sx;
                else if (insn.rrr.subop == SUBOP_SUB)
                    o_result = i_rs_data - i_rt_data;
                else
                    o_result = i_rs_data + i_rt_data;
            end
            OP_CONST:       o_result = imm9_sx;
            OP_LDR, OP_STR: o_result = i_rs_data + imm6_sx;     // effective address
            OP_BR:          o_result = i_pc + 16'd1 + imm9_sx;  // branch target
            default:        o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  wire word_t i_insn,
    output reg_idx_t   o_rs_sel,
    output reg_idx_t   o_rt_sel,
    output reg_idx_t   o_rd_sel,
    output logic       o_rs_re,
    output logic       o_rt_re,
    output logic       o_regfile_we,
    output logic       o_nzp_we,
    output logic       o_is_load,
    output logic       o_is_store,
    output logic       o_is_branch
);

    insn_u insn;
    logic  is_imm;
    logic  arith_ok;

    assign insn     = i_insn;
    assign is_imm   = i_insn[SUBOP_IMM_BIT];
    // MUL, DIV and friends are not in the subset
    assign arith_ok = is_imm || insn.rrr.subop == SUBOP_ADD || insn.rrr.subop == SUBOP_SUB;

    always_comb begin
        o_rs_sel     = insn.rrr.rs;  // rs is [8:6] in every form that has one
        o_rt_sel     = insn.rrr.rt;
        o_rd_sel     = insn.rrr.rd;
        o_rs_re      = 1'b0;         // enables stay low unless the opcode really uses the reg
        o_rt_re      = 1'b0;
        o_regfile_we = 1'b0;
        o_nzp_we     = 1'b0;
        o_is_load    = 1'b0;
        o_is_store   = 1'b0;
        o_is_branch  = 1'b0;
        case (insn.rrr.opcode)
            OP_BR: begin
                o_is_branch = |insn.imm9.rd_nzp;  // empty mask is a no-op, not a branch
            end
            OP_ARITH: begin
                o_rs_re      = arith_ok;
                o_rt_re      = arith_ok && !is_imm;
                o_regfile_we = arith_ok;
                o_nzp_we     = arith_ok;
            end
            OP_CONST: begin
                o_rd_sel     = insn.imm9.rd_nzp;
                o_regfile_we = 1'b1;
                o_nzp_we     = 1'b1;
            end
            OP_LDR: begin
                o_rs_sel     = insn.mem.rs;
                o_rd_sel     = insn.mem.rd_rt;
                o_rs_re      = 1'b1;
                o_regfile_we = 1'b1;
                o_nzp_we     = 1'b1;
                o_is_load    = 1'b1;
            end
            OP_STR: begin
                o_rs_sel   = insn.mem.rs;
                o_rt_sel   = insn.mem.rd_rt;  // store data
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- lc4_golden.txt
# P addr then four program words, D addr then one initial data word
# T test pc insn stall rf_we wsel rf_data nzp_we nzp dm_we dm_addr dm_data
P 8200 9205 95fd 1642 18d1
P 8204 1923 9a10 6d40 1d81
P 8208 7d41 6f41 9000 0a02
P 820c 0401 9207 15e1 7414
P 8210 6610 7615 6815 0000
D 0010 1234
D 0015 beef
T reset    0000 0000 2 0 0 0000 0 0 0 0000 0000
T reset    0000 0000 2 0 0 0000 0 0 0 0000 0000
T reset    0000 0000 2 0 0 0000 0 0 0 0000 0000
T reset    0000 0000 2 0 0 0000 0 0 0 0000 0000
T arith    8200 9205 0 1 1 0005 1 1 0 0000 0000
T arith    8201 95fd 0 1 2 fffd 1 4 0 0000 0000
T bypass   8202 1642 0 1 3 0002 1 1 0 0000 0000
T bypass   8203 18d1 0 1 4 fffd 1 4 0 0000 0000
T bypass   8204 1923 0 1 4 0000 1 2 0 0000 0000
T arith    8205 9a10 0 1 5 0010 1 1 0 0000 0000
T load_use 8206 6d40 0 1 6 1234 1 1 0 0010 1234
T load_use 0000 0000 3 0 0 0000 0 0 0 0000 0000
T load_use 8207 1d81 0 1 6 1239 1 1 0 0000 0000
T store    8208 7d41 0 0 0 0000 0 0 1 0011 1239
T store    8209 6f41 0 1 7 1239 1 1 0 0011 1239
T branch   820a 9000 0 1 0 0000 1 2 0 0000 0000
T branch   820b 0a02 0 0 0 0000 0 0 0 0000 0000
T branch   820c 0401 0 0 0 0000 0 0 0 0000 0000
T branch   0000 0000 2 0 0 0000 0 0 0 0000 0000
T branch   0000 0000 2 0 0 0000 0 0 0 0000 0000
T branch   820e 15e1 0 1 2 123a 1 1 0 0000 0000
T store    820f 7414 0 0 0 0000 0 0 1 0014 123a
T store    8210 6610 0 1 3 1234 1 1 0 0010 1234
T store    8211 7615 0 0 0 0000 0 0 1 0015 1234
T store    8212 6815 0 1 4 1234 1 1 0 0015 1234

//--- lc4_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit
    import lc4_pipe_pkg::*;
(
    input  wire reg_idx_t i_d_rs_sel,
    input  wire reg_idx_t i_d_rt_sel,
    input  wire logic     i_d_rs_re,
    input  wire logic     i_d_rt_re,
    input  wire logic     i_d_is_store,
    input  wire logic     i_d_is_branch,
    input  wire reg_idx_t i_x_rs_sel,
    input  wire reg_idx_t i_x_rt_sel,
    input  wire reg_idx_t i_x_rd_sel,
    input  wire logic     i_x_rs_re,
    input  wire logic     i_x_rt_re,
    input  wire logic     i_x_is_load,
    input  wire logic     i_x_is_branch,
    input  wire nzp_t     i_x_nzp_mask,
    input  wire nzp_t     i_x_nzp,
    input  wire stall_e   i_x_stall,
    input  wire reg_idx_t i_m_rd_sel,
    input  wire logic     i_m_regfile_we,
    input  wire logic     i_m_nzp_we,
    input  wire nzp_t     i_m_nzp,
    input  wire reg_idx_t i_m_rt_sel,
    input  wire logic     i_m_is_store,
    input  wire reg_idx_t i_w_rd_sel,
    input  wire logic     i_w_regfile_we,
    input  wire logic     i_w_nzp_we,
    input  wire nzp_t     i_w_nzp,
    output logic          o_load_stall,
    output logic [1:0]    o_rs_bypass,
    output logic [1:0]    o_rt_bypass,
    output logic          o_store_bypass,
    output logic          o_branch_taken
);

    logic d_uses_x_rd;
    nzp_t branch_nzp;

    // store data is not a reader here since the load reaches it through WM
    assign d_uses_x_rd = (i_d_rs_re && i_d_rs_sel == i_x_rd_sel)
                      || (i_d_rt_re && !i_d_is_store && i_d_rt_sel == i_x_rd_sel);

    // a branch behind a load waits one cycle so it sees the load's NZP from W
    assign o_load_stall = i_x_is_load && i_x_stall == STALL_NONE
                       && (d_uses_x_rd || i_d_is_branch);

    // MX wins since M holds the younger writer
    assign o_rs_bypass = (i_x_rs_re && i_m_regfile_we && i_m_rd_sel == i_x_rs_sel) ? BYP_M :
                         (i_x_rs_re && i_w_regfile_we && i_w_rd_sel == i_x_rs_sel) ? BYP_W :
                         BYP_NONE;
    assign o_rt_bypass = (i_x_rt_re && i_m_regfile_we && i_m_rd_sel == i_x_rt_sel) ? BYP_M :
                         (i_x_rt_re && i_w_regfile_we && i_w_rd_sel == i_x_rt_sel) ? BYP_W :
                         BYP_NONE;

    assign o_store_bypass = i_m_is_store && i_w_regfile_we && i_w_rd_sel == i_m_rt_sel;

    assign branch_nzp = i_m_nzp_we ? i_m_nzp :
                        i_w_nzp_we ? i_w_nzp :
                        i_x_nzp;   // architectural NZP
    assign o_branch_taken = i_x_is_branch && i_x_stall == STALL_NONE
                         && |(i_x_nzp_mask & branch_nzp);

endmodule

`default_nettype wire

//--- lc4_isa_pkg.sv
`default_nettype none

package lc4_isa_pkg;

    typedef logic [15:0] word_t;

    // opcode sits in [15:12]; only these are executed, anything else is a no-op
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    localparam logic [2:0] SUBOP_ADD     = 3'b000;
    localparam logic [2:0] SUBOP_SUB     = 3'b010;
    localparam int         SUBOP_IMM_BIT = 5;      // set means ADD rd, rs, imm5

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] subop;  // imm5 form reuses [4:0]
        logic [2:0] rt;
    } rrr_view_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd_nzp; // rd for CONST, mask for BR
        logic [8:0] imm9;
    } imm9_view_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd_rt;  // rd for LDR, rt for STR
        logic [2:0] rs;
        logic [5:0] imm6;
    } mem_view_t;

    // one word, decoded by opcode
    typedef union packed {
        rrr_view_t  rrr;
        imm9_view_t imm9;
        mem_view_t  mem;
    } insn_u;

    localparam word_t RESET_PC = 16'h8200;
    localparam word_t NOP_INSN = 16'h0000;  // BR with empty mask

endpackage

`default_nettype wire

//--- lc4_pipe_pkg.sv
`default_nettype none

package lc4_pipe_pkg;

    typedef logic [2:0] reg_idx_t;
    typedef logic [2:0] nzp_t;      // {n, z, p}

    // trace stall code without the dual-issue code 1
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_e;

    localparam int NUM_REGS = 8;

    // ALU operand source
    localparam logic [1:0] BYP_NONE = 2'd0;
    localparam logic [1:0] BYP_M    = 2'd1;
    localparam logic [1:0] BYP_W    = 2'd2;

endpackage

`default_nettype wire

//--- lc4_processor.f
lc4_isa_pkg.sv
lc4_pipe_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_hazard_unit.sv
lc4_processor.sv
lc4_trace_checker.sv
tb_lc4_processor.sv

//--- lc4_processor.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_processor
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  wire logic  gwe,
    input  wire logic  i_rst_n,
    output word_t      o_cur_pc,
    input  wire word_t i_cur_insn,
    output word_t      o_dmem_addr,
    input  wire word_t i_cur_dmem_data,
    output logic       o_dmem_we,
    output word_t      o_dmem_towrite,
    output stall_e     o_test_stall,
    output word_t      o_test_pc,
    output word_t      o_test_insn,
    output logic       o_test_regfile_we,
    output reg_idx_t   o_test_regfile_wsel,
    output word_t      o_test_regfile_data,
    output logic       o_test_nzp_we,
    output nzp_t       o_test_nzp_bits,
    output logic       o_test_dmem_we,
    output word_t      o_test_dmem_addr,
    output word_t      o_test_dmem_data
);

    word_t    d_pc, d_insn, d_rs_data, d_rt_data;
    stall_e   d_stall;
    reg_idx_t d_rs_sel, d_rt_sel, d_rd_sel;
    logic     d_rs_re, d_rt_re, d_regfile_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;

    word_t    x_pc, x_insn, x_rs_data, x_rt_data, x_rs_op, x_rt_op, x_alu;
    insn_u    x_view;
    stall_e   x_stall;
    reg_idx_t x_rs_sel, x_rt_sel, x_rd_sel;
    logic     x_rs_re, x_rt_re, x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;

    word_t    m_pc, m_insn, m_alu, m_rt_data, m_wdata;
    stall_e   m_stall;
    reg_idx_t m_rd_sel, m_rt_sel;
    logic     m_regfile_we, m_nzp_we, m_is_load, m_is_store;
    nzp_t     m_nzp;

    word_t    w_pc, w_insn, w_wdata, w_dmem_addr, w_dmem_towrite, w_dmem_rdata;
    stall_e   w_stall;
    reg_idx_t w_rd_sel;
    logic     w_regfile_we, w_nzp_we, w_is_load, w_is_store;
    nzp_t     w_nzp, nzp_reg;

    logic       load_stall, store_bypass, branch_taken;
    logic [1:0] rs_bypass, rt_bypass;

    // a taken branch beats a load stall at fetch
    always_ff @(posedge gwe) begin
        if (!i_rst_n)
            o_cur_pc <= RESET_PC;
        else if (branch_taken)
            o_cur_pc <= x_alu;
        else if (!load_stall)
            o_cur_pc <= o_cur_pc + 16'd1;
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            d_pc    <= '0;
            d_insn  <= NOP_INSN;
            d_stall <= STALL_FLUSH;
        end else if (branch_taken) begin
            d_pc    <= o_cur_pc;     // wrong-path fetch becomes a bubble
            d_insn  <= NOP_INSN;
            d_stall <= STALL_FLUSH;
        end else if (!load_stall) begin
            d_pc    <= o_cur_pc;
            d_insn  <= i_cur_insn;
            d_stall <= STALL_NONE;
        end
    end

    lc4_decoder lc4_decoder_inst (
        .i_insn       (d_insn),
        .o_rs_sel     (d_rs_sel),
        .o_rt_sel     (d_rt_sel),
        .o_rd_sel     (d_rd_sel),
        .o_rs_re      (d_rs_re),
        .o_rt_re      (d_rt_re),
        .o_regfile_we (d_regfile_we),
        .o_nzp_we     (d_nzp_we),
        .o_is_load    (d_is_load),
        .o_is_store   (d_is_store),
        .o_is_branch  (d_is_branch)
    );

    lc4_regfile lc4_regfile_inst (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (d_rs_sel),
        .i_rt_sel  (d_rt_sel),
        .i_rd_sel  (w_rd_sel),
        .i_wdata   (w_wdata),
        .i_we      (w_regfile_we),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data)
    );

    // D to X carries a bubble on reset, flush or load-use
    always_ff @(posedge gwe) begin
        if (!i_rst_n || branch_taken || load_stall) begin
            x_pc         <= i_rst_n ? d_pc : '0;
            x_insn       <= NOP_INSN;
            x_stall      <= (i_rst_n && !branch_taken) ? STALL_LOAD : STALL_FLUSH;
            x_rs_re      <= 1'b0;
            x_rt_re      <= 1'b0;
            x_regfile_we <= 1'b0;
            x_nzp_we     <= 1'b0;
            x_is_load    <= 1'b0;
            x_is_store   <= 1'b0;
            x_is_branch  <= 1'b0;
        end else begin
            x_pc         <= d_pc;
            x_insn       <= d_insn;
            x_stall      <= d_stall;
            x_rs_re      <= d_rs_re;
            x_rt_re      <= d_rt_re;
            x_regfile_we <= d_regfile_we;
            x_nzp_we     <= d_nzp_we;
            x_is_load    <= d_is_load;
            x_is_store   <= d_is_store;
            x_is_branch  <= d_is_branch;
        end
        x_rs_sel  <= d_rs_sel;
        x_rt_sel  <= d_rt_sel;
        x_rd_sel  <= d_rd_sel;
        x_rs_data <= d_rs_data;
        x_rt_data <= d_rt_data;
    end

    // MX forwards the M ALU result and load data reaches stores through WM
    assign x_view  = x_insn;
    assign x_rs_op = (rs_bypass == BYP_M) ? m_alu : (rs_bypass == BYP_W) ? w_wdata : x_rs_data;
    assign x_rt_op = (rt_bypass == BYP_M) ? m_alu : (rt_bypass == BYP_W) ? w_wdata : x_rt_data;

    lc4_alu lc4_alu_inst (
        .i_insn    (x_insn),
        .i_pc      (x_pc),
        .i_rs_data (x_rs_op),
        .i_rt_data (x_rt_op),
        .o_result  (x_alu)
    );

    lc4_hazard_unit lc4_hazard_unit_inst (
        .i_d_rs_sel     (d_rs_sel),
        .i_d_rt_sel     (d_rt_sel),
        .i_d_rs_re      (d_rs_re),
        .i_d_rt_re      (d_rt_re),
        .i_d_is_store   (d_is_store),
        .i_d_is_branch  (d_is_branch),
        .i_x_rs_sel     (x_rs_sel),
        .i_x_rt_sel     (x_rt_sel),
        .i_x_rd_sel     (x_rd_sel),
        .i_x_rs_re      (x_rs_re),
        .i_x_rt_re      (x_rt_re),
        .i_x_is_load    (x_is_load),
        .i_x_is_branch  (x_is_branch),
        .i_x_nzp_mask   (x_view.imm9.rd_nzp),
        .i_x_nzp        (nzp_reg),
        .i_x_stall      (x_stall),
        .i_m_rd_sel     (m_rd_sel),
        .i_m_regfile_we (m_regfile_we),
        .i_m_nzp_we     (m_nzp_we),
        .i_m_nzp        (m_nzp),
        .i_m_rt_sel     (m_rt_sel),
        .i_m_is_store   (m_is_store),
        .i_w_rd_sel     (w_rd_sel),
        .i_w_regfile_we (w_regfile_we),
        .i_w_nzp_we     (w_nzp_we),
        .i_w_nzp        (w_nzp),
        .o_load_stall   (load_stall),
        .o_rs_bypass    (rs_bypass),
        .o_rt_bypass    (rt_bypass),
        .o_store_bypass (store_bypass),
        .o_branch_taken (branch_taken)
    );

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            m_pc         <= '0;
            m_insn       <= NOP_INSN;
            m_stall      <= STALL_FLUSH;
            m_regfile_we <= 1'b0;
            m_nzp_we     <= 1'b0;
            m_is_load    <= 1'b0;
            m_is_store   <= 1'b0;
        end else begin
            m_pc         <= x_pc;
            m_insn       <= x_insn;
            m_stall      <= x_stall;
            m_regfile_we <= x_regfile_we;
            m_nzp_we     <= x_nzp_we;
            m_is_load    <= x_is_load;
            m_is_store   <= x_is_store;
        end
        m_rd_sel  <= x_rd_sel;
        m_rt_sel  <= x_rt_sel;
        m_alu     <= x_alu;
        m_rt_data <= x_rt_op;  // store data after the X bypass
    end

    // data memory answers in the same cycle
    assign o_dmem_addr    = (m_is_load || m_is_store) ? m_alu : '0;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = store_bypass ? w_wdata : m_rt_data;  // WM
    assign m_wdata        = m_is_load ? i_cur_dmem_data : m_alu;
    assign m_nzp          = m_wdata[15] ? 3'b100 : (m_wdata == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            w_pc         <= '0;
            w_insn       <= NOP_INSN;
            w_stall      <= STALL_FLUSH;
            w_regfile_we <= 1'b0;
            w_nzp_we     <= 1'b0;
            w_is_load    <= 1'b0;
            w_is_store   <= 1'b0;
        end else begin
            w_pc         <= m_pc;
            w_insn       <= m_insn;
            w_stall      <= m_stall;
            w_regfile_we <= m_regfile_we;
            w_nzp_we     <= m_nzp_we;
            w_is_load    <= m_is_load;
            w_is_store   <= m_is_store;
        end
        w_rd_sel       <= m_rd_sel;
        w_wdata        <= m_wdata;
        w_nzp          <= m_nzp;
        w_dmem_addr    <= o_dmem_addr;     // kept for the trace
        w_dmem_towrite <= o_dmem_towrite;
        w_dmem_rdata   <= i_cur_dmem_data;
    end

    // NZP commits at writeback while younger values reach X through the hazard unit
    always_ff @(posedge gwe) begin
        if (!i_rst_n)
            nzp_reg <= '0;
        else if (w_nzp_we)
            nzp_reg <= w_nzp;
    end

    assign o_test_stall        = w_stall;
    assign o_test_pc           = w_pc;
    assign o_test_insn         = w_insn;
    assign o_test_regfile_we   = w_regfile_we;
    assign o_test_regfile_wsel = w_rd_sel;
    assign o_test_regfile_data = w_wdata;
    assign o_test_nzp_we       = w_nzp_we;
    assign o_test_nzp_bits     = w_nzp;
    assign o_test_dmem_we      = w_is_store;
    assign o_test_dmem_addr    = w_dmem_addr;
    assign o_test_dmem_data    = w_is_load ? w_dmem_rdata : w_is_store ? w_dmem_towrite : '0;

    // the load-use bubble in X must clear the stall on the next cycle
    assert property (@(posedge gwe) disable iff (!i_rst_n) load_stall |=> !load_stall)
        else $error("load stall held for two cycles");

    // bubbles never reach memory with a live store
    assert property (@(posedge gwe) disable iff (!i_rst_n) o_dmem_we |-> m_stall == STALL_NONE)
        else $error("store issued from a bubble, M stall code %0d", m_stall);

endmodule

`default_nettype wire

//--- lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  wire logic     gwe,
    input  wire logic     i_rst_n,
    input  wire reg_idx_t i_rs_sel,
    input  wire reg_idx_t i_rt_sel,
    input  wire reg_idx_t i_rd_sel,
    input  wire word_t    i_wdata,
    input  wire logic     i_we,
    output word_t         o_rs_data,
    output word_t         o_rt_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // write-through so D sees what W writes this cycle
    assign o_rs_data = (i_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- lc4_trace_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_trace_checker
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  wire logic     gwe,
    input  wire logic     i_rst_n,
    input  wire stall_e   i_stall,
    input  wire word_t    i_pc,
    input  wire word_t    i_insn,
    input  wire logic     i_regfile_we,
    input  wire reg_idx_t i_regfile_wsel,
    input  wire word_t    i_regfile_data,
    input  wire logic     i_nzp_we,
    input  wire nzp_t     i_nzp_bits,
    input  wire logic     i_dmem_we,
    input  wire word_t    i_dmem_addr,
    input  wire word_t    i_dmem_data,
    output logic          o_done,
    output int            o_num_records,
    output int            o_checked,
    output int            o_mismatches,
    output int            o_other_errors
);

    word_t           golden [$];  // 11 words per trace record in file column order
    logic [8*12-1:0] names  [$];  // test tag of each record

    function automatic string field_name(input int f);
        case (f)
            0:       return "pc";
            1:       return "insn";
            2:       return "stall";
            3:       return "regfile_we";
            4:       return "regfile_wsel";
            5:       return "regfile_data";
            6:       return "nzp_we";
            7:       return "nzp_bits";
            8:       return "dmem_we";
            9:       return "dmem_addr";
            default: return "dmem_data";
        endcase
    endfunction

    // pc and insn count only outside bubbles and reg and nzp values only when written
    function automatic logic field_checked(input int r, input int f);
        int base;
        base = r * 11;
        case (f)
            0, 1:    return golden[base + 2] == 16'd0;
            4, 5:    return golden[base + 3] != 16'd0;
            7:       return golden[base + 6] != 16'd0;
            default: return 1'b1;
        endcase
    endfunction

    task automatic compare_record(input int r);
        word_t actual [11];
        actual[0]  = i_pc;
        actual[1]  = i_insn;
        actual[2]  = 16'(i_stall);
        actual[3]  = 16'(i_regfile_we);
        actual[4]  = 16'(i_regfile_wsel);
        actual[5]  = i_regfile_data;
        actual[6]  = 16'(i_nzp_we);
        actual[7]  = 16'(i_nzp_bits);
        actual[8]  = 16'(i_dmem_we);
        actual[9]  = i_dmem_addr;
        actual[10] = i_dmem_data;
        for (int f = 0; f < 11; f++) begin
            if (field_checked(r, f) && actual[f] !== golden[r * 11 + f]) begin
                o_mismatches++;
                $display("Error: %0s record %0d %0s expected %h actual %h",
                         names[r], r, field_name(f), golden[r * 11 + f], actual[f]);
            end
        end
    endtask

    initial begin : load_and_check
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [8*12-1:0]  tag;
        logic [8*256-1:0] rest;
        word_t            value;
        o_done         = 1'b0;
        o_num_records  = 0;
        o_checked      = 0;
        o_mismatches   = 0;
        o_other_errors = 0;
        fd = $fopen("lc4_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open lc4_golden.txt, there is nothing to compare against");
            o_other_errors++;
            o_done = 1'b1;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "T") begin
                    code = $fscanf(fd, "%s", tag);
                    names.push_back(tag);
                    for (int f = 0; f < 11; f++) begin
                        code = $fscanf(fd, "%h", value);
                        golden.push_back(value);
                    end
                end else begin
                    code = $fgets(rest, fd);  // program, data and comment lines
                end
            end
            $fclose(fd);
            o_num_records = names.size();
            if (o_num_records == 0) begin
                $display("the golden file holds no trace records");
                o_other_errors++;
                o_done = 1'b1;
            end
        end
        // trace is steady at the falling edge with one record per cycle out of reset
        while (!o_done) begin
            @(negedge gwe);
            if (i_rst_n) begin
                compare_record(o_checked);
                o_checked++;
                if (o_checked == o_num_records)
                    o_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_lc4_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_processor
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
();

    logic     gwe;
    logic     rst_n;
    word_t    cur_pc;
    word_t    cur_insn;
    word_t    dmem_addr;
    word_t    dmem_rdata;
    logic     dmem_we;
    word_t    dmem_towrite;
    stall_e   test_stall;
    word_t    test_pc;
    word_t    test_insn;
    logic     test_regfile_we;
    reg_idx_t test_regfile_wsel;
    word_t    test_regfile_data;
    logic     test_nzp_we;
    nzp_t     test_nzp_bits;
    logic     test_dmem_we;
    word_t    test_dmem_addr;
    word_t    test_dmem_data;

    word_t imem [65536];
    word_t dmem [65536];

    logic done;
    int   num_records;
    int   checked;
    int   mismatches;
    int   checker_errors;
    int   load_errors = 0;
    int   timeouts    = 0;

    always #2 gwe = ~gwe;  // 4 ns period

    assign cur_insn   = imem[cur_pc];     // fetch answers in the same cycle
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we)
            dmem[dmem_addr] <= dmem_towrite;  // store commits on the edge
    end

    lc4_processor lc4_processor_inst (
        .gwe                 (gwe),
        .i_rst_n             (rst_n),
        .o_cur_pc            (cur_pc),
        .i_cur_insn          (cur_insn),
        .o_dmem_addr         (dmem_addr),
        .i_cur_dmem_data     (dmem_rdata),
        .o_dmem_we           (dmem_we),
        .o_dmem_towrite      (dmem_towrite),
        .o_test_stall        (test_stall),
        .o_test_pc           (test_pc),
        .o_test_insn         (test_insn),
        .o_test_regfile_we   (test_regfile_we),
        .o_test_regfile_wsel (test_regfile_wsel),
        .o_test_regfile_data (test_regfile_data),
        .o_test_nzp_we       (test_nzp_we),
        .o_test_nzp_bits     (test_nzp_bits),
        .o_test_dmem_we      (test_dmem_we),
        .o_test_dmem_addr    (test_dmem_addr),
        .o_test_dmem_data    (test_dmem_data)
    );

    lc4_trace_checker lc4_trace_checker_inst (
        .gwe            (gwe),
        .i_rst_n        (rst_n),
        .i_stall        (test_stall),
        .i_pc           (test_pc),
        .i_insn         (test_insn),
        .i_regfile_we   (test_regfile_we),
        .i_regfile_wsel (test_regfile_wsel),
        .i_regfile_data (test_regfile_data),
        .i_nzp_we       (test_nzp_we),
        .i_nzp_bits     (test_nzp_bits),
        .i_dmem_we      (test_dmem_we),
        .i_dmem_addr    (test_dmem_addr),
        .i_dmem_data    (test_dmem_data),
        .o_done         (done),
        .o_num_records  (num_records),
        .o_checked      (checked),
        .o_mismatches   (mismatches),
        .o_other_errors (checker_errors)
    );

    // P lines fill instruction memory, D lines fill data memory, T lines belong to the checker
    task automatic load_memories();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [8*256-1:0] rest;
        word_t            addr;
        word_t            value;
        for (int a = 0; a < 65536; a++) begin
            // undecoded TRAP opcode so unused code space runs as no-ops
            imem[16'(a)] = {4'hf, 12'(a) ^ 12'(a >> 12)};
            dmem[16'(a)] = 16'(a) ^ 16'h5a5a;  // address-tagged so a stray load shows up
        end
        fd = $fopen("lc4_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open lc4_golden.txt, memories stay empty");
            load_errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "P") begin
                    code = $fscanf(fd, "%h", addr);
                    for (int i = 0; i < 4; i++) begin
                        code = $fscanf(fd, "%h", value);
                        imem[addr] = value;
                        addr = addr + 16'd1;
                    end
                end else if (kind == "D") begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    dmem[addr] = value;
                end else begin
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic finish_run();
        int other;
        other = load_errors + timeouts + checker_errors;
        $display("errors: %0d value mismatches, %0d other failures", mismatches, other);
        if (mismatches == 0 && other == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    initial begin : main_flow
        gwe   = 1'b0;
        rst_n = 1'b0;
        load_memories();
        repeat (3) @(posedge gwe);
        #0.5 rst_n = 1'b1;  // released just after the edge
        wait (done);
        @(posedge gwe);
        finish_run();
    end

    // one trace record per cycle plus slack for the pipeline to drain
    initial begin : watchdog
        wait (rst_n);
        #((num_records + 20) * 4);
        $display("timeout, the trace stopped after %0d of %0d golden records", checked,
                 num_records);
        timeouts = 1;
        finish_run();
    end

endmodule

`default_nettype wire
